// ==== spike_rate_defines.svh ====
`ifndef SPIKE_RATE_DEFINES_SVH
`define SPIKE_RATE_DEFINES_SVH

// number of asynchronous spike inputs
`define SR_NUM_CHANNELS 4

// running count and result width
// counters stop at all ones
`define SR_CNT_WIDTH 16

// apb address width, byte addressed
`define SR_ADDR_WIDTH 8

// window length register width, in fast clock cycles
`define SR_WIN_WIDTH 16

// shortest window accepted
// smaller writes are clamped up to this
`define SR_MIN_WINDOW 8

`endif

// ==== spike_bus_pkg.sv ====
`include "spike_rate_defines.svh"

package spike_bus_pkg;

    // apb request, driven by the bus master
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`SR_ADDR_WIDTH-1:0] paddr;
        logic [31:0]               pwdata;
    } apb_req_t;

    // apb response back to the master
    // pready is tied high, no wait states
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map, word aligned offsets
    // ctrl bit 0 is enable
    // status bit 0 is done (w1c), bits 15:8 window sequence number
    // result registers start at 0x10, one word per channel
    typedef enum logic [`SR_ADDR_WIDTH-1:0] {
        REG_CTRL    = 8'h00,
        REG_WINDOW  = 8'h04,
        REG_STATUS  = 8'h08,
        REG_RESULT0 = 8'h10
    } reg_addr_e;

endpackage

// ==== spike_count_pkg.sv ====
`include "spike_rate_defines.svh"

package spike_count_pkg;

    // window sequencing states
    typedef enum logic [1:0] {
        WIN_IDLE  = 2'd0,
        WIN_COUNT = 2'd1,
        WIN_LATCH = 2'd2,
        WIN_FLUSH = 2'd3
    } win_state_e;

    // control from the window fsm to timer and counters
    // run   counting window active
    // latch copy running counts to results
    // clear zero running counts, reload timer
    typedef struct packed {
        logic run;
        logic latch;
        logic clear;
    } win_ctrl_t;

    // one result per channel, channel 0 in the low bits
    typedef logic [`SR_NUM_CHANNELS-1:0][`SR_CNT_WIDTH-1:0] count_vec_t;

endpackage

// ==== spike_edge_detect.sv ====
`timescale 1ns/1ps

`include "spike_rate_defines.svh"

module spike_edge_detect (
    input  logic                        reset,
    input  logic                        clk,
    input  logic [`SR_NUM_CHANNELS-1:0] spike,
    output logic [`SR_NUM_CHANNELS-1:0] spike_pulse
);

    // two synchronizer stages per channel
    logic [`SR_NUM_CHANNELS-1:0] sync_q1;
    logic [`SR_NUM_CHANNELS-1:0] sync_q2;

    // previous synchronized level, for rising edge detect
    logic [`SR_NUM_CHANNELS-1:0] level_q;

    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            sync_q1     <= '0;
            sync_q2     <= '0;
            level_q     <= '0;
            spike_pulse <= '0;
        end else begin
            // first stage may go metastable
            sync_q1     <= spike;
            sync_q2     <= sync_q1;
            level_q     <= sync_q2;
            // registered one cycle pulse on each rising level
            // lands 3 clocks after the input rises
            spike_pulse <= sync_q2 & ~level_q;
        end
    end

endmodule

// ==== window_timer.sv ====
`timescale 1ns/1ps

`include "spike_rate_defines.svh"

module window_timer (
    input  logic                      reset,
    input  logic                      clk,
    input  spike_count_pkg::win_ctrl_t ctrl,
    input  logic [`SR_WIN_WIDTH-1:0]  window_len,
    output logic                      tick
);

    // cycles left in the current window minus one
    logic [`SR_WIN_WIDTH-1:0] remain_q;

    // reload value for a window of window_len cycles
    logic [`SR_WIN_WIDTH-1:0] reload_val;

    assign reload_val = window_len - `SR_WIN_WIDTH'(1);

    // end of window
    // suppressed in the clear cycle while the timer restarts
    assign tick = ctrl.run && !ctrl.clear && (remain_q == '0);

    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            remain_q <= '0;
        end else if (ctrl.clear) begin
            // fresh window on start
            remain_q <= reload_val;
        end else if (ctrl.run) begin
            if (remain_q == '0) begin
                // reload on the tick edge so windows run back to back
                remain_q <= reload_val;
            end else begin
                remain_q <= remain_q - `SR_WIN_WIDTH'(1);
            end
        end
        // hold while run is low
    end

endmodule

// ==== window_ctrl_fsm.sv ====
`timescale 1ns/1ps

module window_ctrl_fsm (
    input  logic                       reset,
    input  logic                       clk,
    input  logic                       enable,
    input  logic                       tick,
    output spike_count_pkg::win_ctrl_t ctrl,
    output logic                       window_end
);

    spike_count_pkg::win_state_e state_q;
    spike_count_pkg::win_state_e state_d;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            spike_count_pkg::WIN_IDLE: begin
                if (enable) begin
                    state_d = spike_count_pkg::WIN_COUNT;
                end
            end
            spike_count_pkg::WIN_COUNT: begin
                // disable wins over a tick, both latch anyway
                if (!enable) begin
                    state_d = spike_count_pkg::WIN_FLUSH;
                end else if (tick) begin
                    state_d = spike_count_pkg::WIN_LATCH;
                end
            end
            // single cycle states
            spike_count_pkg::WIN_LATCH: state_d = spike_count_pkg::WIN_COUNT;
            spike_count_pkg::WIN_FLUSH: state_d = spike_count_pkg::WIN_IDLE;
            default: state_d = spike_count_pkg::WIN_IDLE;
        endcase
    end

    // state and outputs registered from next state
    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            state_q    <= spike_count_pkg::WIN_IDLE;
            ctrl       <= '0;
        end else begin
            state_q    <= state_d;
            // timer keeps running through the latch cycle
            ctrl.run   <= (state_d == spike_count_pkg::WIN_COUNT) ||
                          (state_d == spike_count_pkg::WIN_LATCH);
            ctrl.latch <= (state_d == spike_count_pkg::WIN_LATCH) ||
                          (state_d == spike_count_pkg::WIN_FLUSH);
            // one pulse when leaving idle
            ctrl.clear <= (state_q == spike_count_pkg::WIN_IDLE) &&
                          (state_d == spike_count_pkg::WIN_COUNT);
        end
    end

    // every latch closes a window, periodic or flush
    assign window_end = ctrl.latch;

endmodule

// ==== spike_channel_counter.sv ====
`timescale 1ns/1ps

`include "spike_rate_defines.svh"

module spike_channel_counter (
    input  logic                        reset,
    input  logic                        clk,
    input  spike_count_pkg::win_ctrl_t  ctrl,
    input  logic [`SR_NUM_CHANNELS-1:0] spike_pulse,
    output spike_count_pkg::count_vec_t results
);

    // saturation value of a running count
    localparam logic [`SR_CNT_WIDTH-1:0] CNT_MAX = '1;

    // running counts for the open window
    spike_count_pkg::count_vec_t count_q;

    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            count_q <= '0;
            results <= '0;
        end else begin
            for (int ch = 0; ch < `SR_NUM_CHANNELS; ch++) begin
                if (ctrl.clear) begin
                    // results kept, software may still read them
                    count_q[ch] <= '0;
                end else if (ctrl.latch) begin
                    results[ch] <= count_q[ch];
                    // an edge in the latch cycle opens the new window
                    count_q[ch] <= spike_pulse[ch] ? `SR_CNT_WIDTH'(1) : '0;
                end else if (ctrl.run && spike_pulse[ch]) begin
                    // stop at all ones, no wrap
                    if (count_q[ch] != CNT_MAX) begin
                        count_q[ch] <= count_q[ch] + `SR_CNT_WIDTH'(1);
                    end
                end
            end
        end
    end

endmodule

// ==== spike_apb_regs.sv ====
`timescale 1ns/1ps

`include "spike_rate_defines.svh"

module spike_apb_regs (
    input  logic                        reset,
    input  logic                        clk,
    input  spike_bus_pkg::apb_req_t     req,
    output spike_bus_pkg::apb_rsp_t     rsp,
    input  spike_count_pkg::count_vec_t results,
    input  logic                        window_end,
    output logic                        enable,
    output logic [`SR_WIN_WIDTH-1:0]    window_len,
    output logic                        irq
);

    localparam logic [`SR_WIN_WIDTH-1:0] MIN_WIN = `SR_MIN_WINDOW;

    // sticky window done and window sequence counter
    logic       done_q;
    logic [7:0] seq_q;

    // decode results
    logic        access;
    logic        addr_hit;
    logic        is_result;
    logic        err;
    logic        wr_en;
    logic [31:0] rd_data;

    // value written to the window register
    logic [`SR_WIN_WIDTH-1:0] wr_window;

    // access phase of a transfer
    assign access = req.psel && req.penable;

    // address decode and read mux
    always_comb begin
        addr_hit  = 1'b1;
        is_result = 1'b0;
        rd_data   = '0;
        case (req.paddr)
            spike_bus_pkg::REG_CTRL: begin
                rd_data[0] = enable;
            end
            spike_bus_pkg::REG_WINDOW: begin
                rd_data[`SR_WIN_WIDTH-1:0] = window_len;
            end
            spike_bus_pkg::REG_STATUS: begin
                rd_data[0]    = done_q;
                rd_data[15:8] = seq_q;
            end
            default: begin
                // result block, one word per channel
                addr_hit = 1'b0;
                for (int ch = 0; ch < `SR_NUM_CHANNELS; ch++) begin
                    if (req.paddr == (spike_bus_pkg::REG_RESULT0 +
                                      `SR_ADDR_WIDTH'(4 * ch))) begin
                        addr_hit  = 1'b1;
                        is_result = 1'b1;
                        rd_data[`SR_CNT_WIDTH-1:0] = results[ch];
                    end
                end
            end
        endcase
    end

    // unmapped address, or write to a read only result
    assign err   = access && (!addr_hit || (req.pwrite && is_result));
    assign wr_en = access && req.pwrite && !err;

    // clamp short windows
    assign wr_window = req.pwdata[`SR_WIN_WIDTH-1:0];

    always_ff @(posedge reset or negedge clk) begin
        if (!clk) begin
            enable     <= 1'b0;
            window_len <= MIN_WIN;
            done_q     <= 1'b0;
            seq_q      <= '0;
        end else begin
            if (wr_en) begin
                case (req.paddr)
                    spike_bus_pkg::REG_CTRL: enable <= req.pwdata[0];
                    spike_bus_pkg::REG_WINDOW: begin
                        window_len <= (wr_window < MIN_WIN) ? MIN_WIN : wr_window;
                    end
                    default: ;
                endcase
            end
            // set beats a same cycle w1c
            if (window_end) begin
                done_q <= 1'b1;
                seq_q  <= seq_q + 8'd1;
            end else if (wr_en && req.paddr == spike_bus_pkg::REG_STATUS &&
                         req.pwdata[0]) begin
                done_q <= 1'b0;
            end
        end
    end

    // response valid in the access phase only
    assign rsp.prdata  = access ? rd_data : '0;
    assign rsp.pready  = 1'b1;
    assign rsp.pslverr = err;

    assign irq = done_q;

endmodule

// ==== spike_rate_top.sv ====
`timescale 1ns/1ps

`include "spike_rate_defines.svh"

module spike_rate_top (
    input  logic                        reset,
    input  logic                        clk,
    input  spike_bus_pkg::apb_req_t     apb_req,
    output spike_bus_pkg::apb_rsp_t     apb_rsp,
    input  logic [`SR_NUM_CHANNELS-1:0] spike,
    output logic                        irq
);

    // synchronized edges into the counters
    logic [`SR_NUM_CHANNELS-1:0] spike_pulse;

    // software controls
    logic                     enable;
    logic [`SR_WIN_WIDTH-1:0] window_len;

    // window sequencing
    logic                        tick;
    logic                        window_end;
    spike_count_pkg::win_ctrl_t  win_ctrl;
    spike_count_pkg::count_vec_t results;

    spike_edge_detect u_edge (
        .reset       (reset),
        .clk         (clk),
        .spike       (spike),
        .spike_pulse (spike_pulse)
    );

    window_timer u_timer (
        .reset      (reset),
        .clk        (clk),
        .ctrl       (win_ctrl),
        .window_len (window_len),
        .tick       (tick)
    );

    window_ctrl_fsm u_fsm (
        .reset      (reset),
        .clk        (clk),
        .enable     (enable),
        .tick       (tick),
        .ctrl       (win_ctrl),
        .window_end (window_end)
    );

    spike_channel_counter u_counter (
        .reset       (reset),
        .clk         (clk),
        .ctrl        (win_ctrl),
        .spike_pulse (spike_pulse),
        .results     (results)
    );

    spike_apb_regs u_regs (
        .reset      (reset),
        .clk        (clk),
        .req        (apb_req),
        .rsp        (apb_rsp),
        .results    (results),
        .window_end (window_end),
        .enable     (enable),
        .window_len (window_len),
        .irq        (irq)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic reset,
    output logic clk
);

    // reset carries the 20 ns clock
    initial begin
        reset = 1'b0;
        forever #10 reset = ~reset;
    end

    // clk is the active low reset, held for 3 clock cycles
    initial begin
        clk = 1'b0;
        repeat (3) @(posedge reset);
        clk <= 1'b1;
    end

endmodule

// ==== tb_spike_rate.sv ====
`timescale 1ns/1ps

`include "spike_rate_defines.svh"

module tb_spike_rate;

    // short tests take well under 2000 cycles
    localparam int BASE_LIMIT = 20000;
    // one 65535 cycle window plus start and polling
    localparam int LONG_LIMIT = 70000;
    localparam int CNT_MAX    = (1 << `SR_CNT_WIDTH) - 1;

    // reset is the clock, clk the active low reset
    logic                        reset;
    logic                        clk;
    spike_bus_pkg::apb_req_t     apb_req;
    spike_bus_pkg::apb_rsp_t     apb_rsp;
    logic [`SR_NUM_CHANNELS-1:0] spike;
    logic                        irq;

    // pulses per channel in the current test
    int          pulse_cnt [`SR_NUM_CHANNELS];
    int          timeout_limit;
    int          cycle_count;
    logic [31:0] seed_val;
    logic [31:0] rdata;

    tb_clock_gen u_clk_gen (
        .reset (reset),
        .clk   (clk)
    );

    spike_rate_top u_dut (
        .reset   (reset),
        .clk     (clk),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .spike   (spike),
        .irq     (irq)
    );

    always @(posedge reset) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run still going after %0d cycles", timeout_limit);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // setup, access, then idle; response sampled mid access cycle
    task automatic apb_transfer(input logic wr, input logic [`SR_ADDR_WIDTH-1:0] addr,
                                input logic [31:0] wdata, input logic exp_err,
                                output logic [31:0] data);
        spike_bus_pkg::apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = wr;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(posedge reset);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge reset);
        apb_req <= req;
        @(negedge reset);
        assert (apb_rsp.pready === 1'b1) else begin
            $display("pready was low in the access phase at address 0x%0h", addr);
            $display("Test FAILED");
            $fatal(1);
        end
        check_value($sformatf("pslverr at 0x%0h", addr), 32'(exp_err), 32'(apb_rsp.pslverr));
        data = apb_rsp.prdata;
        @(posedge reset);
        apb_req <= '0;
    endtask

    task automatic write_reg(input logic [`SR_ADDR_WIDTH-1:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_data;
        apb_transfer(1'b1, addr, wdata, 1'b0, unused_data);
    endtask

    task automatic read_reg(input logic [`SR_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        apb_transfer(1'b0, addr, 32'h0, 1'b0, data);
    endtask

    function automatic logic [`SR_ADDR_WIDTH-1:0] result_addr(input int ch);
        return spike_bus_pkg::REG_RESULT0 + `SR_ADDR_WIDTH'(4 * ch);
    endfunction

    task automatic irq_matches(input string name, input logic expected);
        @(negedge reset);
        check_value(name, 32'(expected), 32'(irq));
    endtask

    // expected result follows pulse_cnt, stopping at all ones
    task automatic compare_results(input string name);
        logic [31:0] data;
        int          expected;
        for (int ch = 0; ch < `SR_NUM_CHANNELS; ch++) begin
            expected = (pulse_cnt[ch] > CNT_MAX) ? CNT_MAX : pulse_cnt[ch];
            read_reg(result_addr(ch), data);
            check_value($sformatf("%s result%0d", name, ch), expected, data);
        end
    endtask

    // all channels share slots, 2 cycles high and 2 low
    task automatic send_pulses();
        int                          max_cnt;
        logic [`SR_NUM_CHANNELS-1:0] mask;
        max_cnt = 0;
        for (int ch = 0; ch < `SR_NUM_CHANNELS; ch++) begin
            if (pulse_cnt[ch] > max_cnt) max_cnt = pulse_cnt[ch];
        end
        for (int slot = 0; slot < max_cnt; slot++) begin
            for (int ch = 0; ch < `SR_NUM_CHANNELS; ch++) mask[ch] = (slot < pulse_cnt[ch]);
            @(posedge reset);
            spike <= mask;
            @(posedge reset);
            @(posedge reset);
            spike <= '0;
            @(posedge reset);
        end
        // last edges still in the synchronizer
        repeat (6) @(posedge reset);
    endtask

    task automatic wait_done(input int max_polls);
        int          polls;
        logic [31:0] status;
        polls  = 0;
        status = '0;
        while (status[0] !== 1'b1 && polls < max_polls) begin
            read_reg(spike_bus_pkg::REG_STATUS, status);
            polls++;
        end
        assert (status[0] === 1'b1) else begin
            $display("done flag still clear after %0d status polls", max_polls);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic reset_values();
        pulse_cnt = '{default: 0};
        read_reg(spike_bus_pkg::REG_CTRL, rdata);
        check_value("reset_values ctrl", 32'h0, rdata);
        read_reg(spike_bus_pkg::REG_WINDOW, rdata);
        check_value("reset_values window", `SR_MIN_WINDOW, rdata);
        read_reg(spike_bus_pkg::REG_STATUS, rdata);
        check_value("reset_values status", 32'h0, rdata);
        compare_results("reset_values");
        irq_matches("reset_values irq", 1'b0);
        // short window clamped up
        write_reg(spike_bus_pkg::REG_WINDOW, 32'd3);
        read_reg(spike_bus_pkg::REG_WINDOW, rdata);
        check_value("reset_values clamp", `SR_MIN_WINDOW, rdata);
    endtask

    task automatic first_window();
        write_reg(spike_bus_pkg::REG_WINDOW, 32'd200);
        for (int ch = 0; ch < `SR_NUM_CHANNELS; ch++) pulse_cnt[ch] = $urandom % 31;
        write_reg(spike_bus_pkg::REG_CTRL, 32'h1);
        repeat (6) @(posedge reset);
        send_pulses();
        wait_done(200);
        compare_results("first_window");
        read_reg(spike_bus_pkg::REG_STATUS, rdata);
        // done set, sequence 1
        check_value("first_window status", 32'h0000_0101, rdata);
        irq_matches("first_window irq", 1'b1);
    endtask

    task automatic done_clear();
        write_reg(spike_bus_pkg::REG_STATUS, 32'h1);
        read_reg(spike_bus_pkg::REG_STATUS, rdata);
        check_value("done_clear status", 32'h0000_0100, rdata);
        irq_matches("done_clear irq", 1'b0);
        pulse_cnt = '{default: 0};
        wait_done(200);
        compare_results("done_clear");
        read_reg(spike_bus_pkg::REG_STATUS, rdata);
        check_value("done_clear next status", 32'h0000_0201, rdata);
    endtask

    task automatic disable_flush();
        write_reg(spike_bus_pkg::REG_STATUS, 32'h1);
        pulse_cnt = '{5, 3, 0, 7};
        send_pulses();
        write_reg(spike_bus_pkg::REG_CTRL, 32'h0);
        wait_done(50);
        compare_results("disable_flush");
        read_reg(spike_bus_pkg::REG_STATUS, rdata);
        check_value("disable_flush status", 32'h0000_0301, rdata);
        // idle now, more than a window passes with no update
        repeat (250) @(posedge reset);
        compare_results("disable_flush idle");
        read_reg(spike_bus_pkg::REG_STATUS, rdata);
        check_value("disable_flush idle status", 32'h0000_0301, rdata);
    endtask

    task automatic bus_errors();
        apb_transfer(1'b0, `SR_ADDR_WIDTH'(8'h40), 32'h0, 1'b1, rdata);
        apb_transfer(1'b1, spike_bus_pkg::REG_RESULT0, 32'hffff, 1'b1, rdata);
        read_reg(spike_bus_pkg::REG_RESULT0, rdata);
        check_value("bus_errors result0", 32'd5, rdata);
        read_reg(spike_bus_pkg::REG_CTRL, rdata);
        check_value("bus_errors ctrl", 32'h0, rdata);
        read_reg(spike_bus_pkg::REG_WINDOW, rdata);
        check_value("bus_errors window", 32'd200, rdata);
    endtask

    // longest window, 4 cycles per pulse, edges stay clear of the boundary
    task automatic long_window();
        timeout_limit = timeout_limit + LONG_LIMIT;
        write_reg(spike_bus_pkg::REG_WINDOW, 32'd65535);
        write_reg(spike_bus_pkg::REG_STATUS, 32'h1);
        pulse_cnt = '{16000, 0, 0, 0};
        write_reg(spike_bus_pkg::REG_CTRL, 32'h1);
        repeat (6) @(posedge reset);
        send_pulses();
        wait_done(2000);
        compare_results("long_window");
        read_reg(spike_bus_pkg::REG_STATUS, rdata);
        check_value("long_window status", 32'h0000_0401, rdata);
    endtask

    initial begin
        apb_req       = '0;
        spike         = '0;
        cycle_count   = 0;
        timeout_limit = BASE_LIMIT;
        seed_val      = $urandom(32'h5366b85d);
        @(posedge clk);
        @(posedge reset);
        reset_values();
        first_window();
        done_clear();
        disable_flush();
        bus_errors();
        long_window();
        $display("Test OK");
        $finish;
    end

endmodule

// ==== spike_rate.f ====
+incdir+.
spike_bus_pkg.sv
spike_count_pkg.sv
spike_edge_detect.sv
window_timer.sv
window_ctrl_fsm.sv
spike_channel_counter.sv
spike_apb_regs.sv
spike_rate_top.sv
tb_clock_gen.sv
tb_spike_rate.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_spike_rate
FILELIST  := spike_rate.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
